// File: common/busPkg.sv
package busPkg;

	typedef logic [15:0] busAddr_t;
	typedef logic [11:0] localAddr_t;
	typedef logic [31:0] busData_t;
	typedef logic [3:0] byteSel_t;
	typedef logic [3:0] deviceId_t;

	// register map inside the device window
	localparam localAddr_t configOffset = 12'h000;
	localparam localAddr_t clearOffset = 12'h004;
	localparam localAddr_t statusOffset = 12'h008;
	localparam localAddr_t rxOffset = 12'h00C;
	localparam localAddr_t txOffset = 12'h010;

	// bus value when nothing answers
	localparam busData_t idleRead = '1;

endpackage

// File: common/uartPkg.sv
package uartPkg;

	typedef logic [7:0] uartByte_t;
	typedef logic [15:0] bitCycles_t;
	typedef logic [20:0] config_t;

	// configuration fields
	localparam int cfgCyclesLsb = 0;
	localparam int cfgCyclesMsb = 15;
	localparam int cfgWaitForTxSpace = 16;
	localparam int cfgEnable = 17;
	localparam int cfgLostIrqEnable = 18;
	localparam int cfgRxIrqEnable = 19;
	localparam int cfgTxDoneIrqEnable = 20;

	// 40 MHz clock at 9600 baud, disabled
	localparam config_t configDefault = 21'h001047;

	// status flags
	localparam int statusBits = 6;
	localparam int statRxAvailable = 0;
	localparam int statRxFull = 1;
	localparam int statRxLost = 2;
	localparam int statTxAvailable = 3;
	localparam int statTxFull = 4;
	localparam int statTxLost = 5;

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_e;
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_e;

endpackage

// File: common/peripheralBusIf.sv
`timescale 1ns/1ps

// request side of the peripheral bus
interface peripheralBusIf;

	logic enable;
	logic we;
	logic oe;
	busPkg::busAddr_t address;
	busPkg::byteSel_t byteSelect;
	busPkg::busData_t dataWrite;

	modport master (
		output enable, we, oe,
		output address, byteSelect, dataWrite
	);

	modport device (
		input enable, we, oe,
		input address, byteSelect, dataWrite
	);

endinterface

// File: common/fifoIf.sv
`timescale 1ns/1ps

interface fifoIf;

	uartPkg::uartByte_t dataIn;
	logic push;
	uartPkg::uartByte_t dataOut;
	logic pop;
	logic isData;
	logic full;
	logic lost;
	logic clear;

	modport buffer (input dataIn, push, pop, clear, output dataOut, isData, full, lost);

	// each user drives only its own strobes
	modport user (output dataIn, push, pop, clear, input dataOut, isData, full, lost);

endinterface

// File: hdl/byteFifo.sv
`timescale 1ns/1ps

module byteFifo #(
	parameter int depth = 32
) (
	input logic clk,
	input logic rst,
	fifoIf.buffer f
);

	localparam int ptrBits = $clog2(depth);
	localparam logic [ptrBits:0] fullCount = (ptrBits + 1)'(depth);

	uartPkg::uartByte_t mem [depth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [ptrBits:0] count;
	logic doPush, doPop;

	assign f.isData = (count != '0);
	assign f.full = (count == fullCount);
	assign f.dataOut = mem[rdPtr];

	// a push into a full buffer is dropped
	assign doPush = f.push && !f.full;
	assign doPop = f.pop && f.isData;

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= f.dataIn;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst || f.clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			f.lost <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (f.push && f.full) begin
				f.lost <= 1'b1;
			end
		end
	end

endmodule

// File: uart/uartRx.sv
`timescale 1ns/1ps

module uartRx (
	input logic clk,
	input logic rst,
	input logic clear,
	input uartPkg::bitCycles_t cyclesPerBit,
	input logic rx,
	output uartPkg::uartByte_t dataOut,
	output logic dataValid
);

	logic [1:0] rxSync;
	logic rxLine;
	uartPkg::rxState_e state;
	uartPkg::bitCycles_t counter;
	logic [2:0] bitIndex;
	uartPkg::uartByte_t shiftReg;

	assign rxLine = rxSync[1];
	assign dataOut = shiftReg;

	// synchronizer resets to the idle level
	always_ff @(posedge clk) begin
		if (rst) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], rx};
		end
	end

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			state <= uartPkg::rxIdle;
			counter <= '0;
			bitIndex <= '0;
			dataValid <= 1'b0;
		end else begin
			dataValid <= 1'b0;
			if (state != uartPkg::rxIdle && counter != '0) begin
				counter <= counter - 1'b1;
			end else begin
				case (state)
					uartPkg::rxIdle: begin
						// wait half a bit to land mid start bit
						if (!rxLine) begin
							state <= uartPkg::rxStart;
							counter <= cyclesPerBit >> 1;
						end
					end
					uartPkg::rxStart: begin
						counter <= cyclesPerBit;
						bitIndex <= '0;
						state <= rxLine ? uartPkg::rxIdle : uartPkg::rxData;
					end
					uartPkg::rxData: begin
						counter <= cyclesPerBit;
						if (bitIndex == 3'd7) begin
							state <= uartPkg::rxStop;
						end else begin
							bitIndex <= bitIndex + 1'b1;
						end
					end
					default: begin
						// framing error when stop reads low, byte discarded
						state <= uartPkg::rxIdle;
						dataValid <= rxLine;
					end
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == uartPkg::rxData && counter == '0) begin
			shiftReg <= {rxLine, shiftReg[7:1]};
		end
	end

endmodule

// File: uart/uartTx.sv
`timescale 1ns/1ps

module uartTx (
	input logic clk,
	input logic rst,
	input logic clear,
	input uartPkg::bitCycles_t cyclesPerBit,
	input logic enable,
	input uartPkg::uartByte_t dataIn,
	input logic dataReady,
	output logic pop,
	output logic tx,
	output logic active
);

	uartPkg::txState_e state;
	uartPkg::bitCycles_t counter;
	logic [2:0] bitIndex;
	uartPkg::uartByte_t shiftReg;
	logic bitEnd;

	assign pop = enable && !clear && (state == uartPkg::txIdle) && dataReady;
	// stays high across back to back frames
	assign active = (state != uartPkg::txIdle) || pop;
	assign bitEnd = (counter == '0);

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			state <= uartPkg::txIdle;
			counter <= '0;
			bitIndex <= '0;
			tx <= 1'b1;
		end else if (state != uartPkg::txIdle && !bitEnd) begin
			counter <= counter - 1'b1;
		end else begin
			case (state)
				uartPkg::txIdle: begin
					if (pop) begin
						state <= uartPkg::txStart;
						counter <= cyclesPerBit;
						tx <= 1'b0;
					end
				end
				uartPkg::txStart: begin
					state <= uartPkg::txData;
					counter <= cyclesPerBit;
					bitIndex <= '0;
					tx <= shiftReg[0];
				end
				uartPkg::txData: begin
					counter <= cyclesPerBit;
					if (bitIndex == 3'd7) begin
						state <= uartPkg::txStop;
						tx <= 1'b1;
					end else begin
						bitIndex <= bitIndex + 1'b1;
						tx <= shiftReg[0];
					end
				end
				default: state <= uartPkg::txIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			shiftReg <= dataIn;
		end else if ((state == uartPkg::txStart || state == uartPkg::txData) && bitEnd) begin
			shiftReg <= shiftReg >> 1;
		end
	end

endmodule

// File: hdl/uartRegisters.sv
`timescale 1ns/1ps

module uartRegisters #(
	parameter busPkg::deviceId_t deviceId = '0
) (
	input logic clk,
	input logic rst,
	peripheralBusIf.device bus,
	output busPkg::busData_t dataRead,
	output logic requestOutput,
	output logic busy,
	fifoIf.user rxBuf,
	fifoIf.user txBuf,
	output uartPkg::bitCycles_t cyclesPerBit,
	output logic uartEnable,
	output logic rxClear,
	output logic txClear,
	input logic txActive,
	output logic irq
);

	busPkg::localAddr_t localAddr;
	logic selected;
	logic configHit, clearHit, statusHit, rxHit, txHit, anyHit;
	logic rxRead, rxReadQ;
	uartPkg::config_t configReg;
	logic [3:0] clearStrobe;
	logic [uartPkg::statusBits-1:0] flagStage;
	logic [uartPkg::statusBits-1:0] statusReg;
	busPkg::busData_t readMux;
	logic txActiveQ, txDone;

	assign selected = bus.enable && (bus.address[15:12] == deviceId);
	assign localAddr = bus.address[11:0];
	assign configHit = selected && (localAddr == busPkg::configOffset);
	assign clearHit = selected && (localAddr == busPkg::clearOffset);
	assign statusHit = selected && (localAddr == busPkg::statusOffset);
	assign rxHit = selected && (localAddr == busPkg::rxOffset);
	assign txHit = selected && (localAddr == busPkg::txOffset);
	assign anyHit = configHit || clearHit || statusHit || rxHit || txHit;

	always_ff @(posedge clk) begin
		if (rst) begin
			configReg <= uartPkg::configDefault;
		end else if (configHit && bus.we) begin
			if (bus.byteSelect[0]) begin
				configReg[7:0] <= bus.dataWrite[7:0];
			end
			if (bus.byteSelect[1]) begin
				configReg[15:8] <= bus.dataWrite[15:8];
			end
			if (bus.byteSelect[2]) begin
				configReg[20:16] <= bus.dataWrite[20:16];
			end
		end
	end

	assign cyclesPerBit = configReg[uartPkg::cfgCyclesMsb:uartPkg::cfgCyclesLsb];
	assign uartEnable = configReg[uartPkg::cfgEnable];

	// one cycle strobes: rx, tx, rx fifo, tx fifo
	always_ff @(posedge clk) begin
		if (rst) begin
			clearStrobe <= '0;
		end else if (clearHit && bus.we && bus.byteSelect[0]) begin
			clearStrobe <= bus.dataWrite[3:0];
		end else begin
			clearStrobe <= '0;
		end
	end

	assign rxClear = clearStrobe[0];
	assign txClear = clearStrobe[1];
	assign rxBuf.clear = clearStrobe[2];
	assign txBuf.clear = clearStrobe[3];

	always_ff @(posedge clk) begin
		if (rst) begin
			flagStage <= '0;
			statusReg <= '0;
		end else begin
			flagStage[uartPkg::statRxAvailable] <= rxBuf.isData;
			flagStage[uartPkg::statRxFull] <= rxBuf.full;
			flagStage[uartPkg::statRxLost] <= rxBuf.lost;
			flagStage[uartPkg::statTxAvailable] <= txBuf.isData;
			flagStage[uartPkg::statTxFull] <= txBuf.full;
			flagStage[uartPkg::statTxLost] <= txBuf.lost;
			statusReg <= flagStage;
		end
	end

	// stall the master only when it asked to wait for space
	assign busy = txHit && bus.we && configReg[uartPkg::cfgWaitForTxSpace]
		&& uartEnable && txBuf.full;
	assign txBuf.push = txHit && bus.we && bus.byteSelect[0] && !busy;
	assign txBuf.dataIn = bus.dataWrite[7:0];

	// pop once per read, even if oe is held
	assign rxRead = rxHit && bus.oe;
	assign rxBuf.pop = rxRead && !rxReadQ;

	always_comb begin
		readMux = '0;
		if (configHit) begin
			readMux = busPkg::busData_t'(configReg);
		end else if (statusHit) begin
			readMux = busPkg::busData_t'(statusReg);
		end else if (rxHit) begin
			readMux[8] = rxBuf.isData;
			readMux[7:0] = rxBuf.dataOut;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rxReadQ <= 1'b0;
			requestOutput <= 1'b0;
			dataRead <= busPkg::idleRead;
		end else begin
			rxReadQ <= rxRead;
			if (anyHit && bus.oe) begin
				requestOutput <= 1'b1;
				if (!(rxHit && rxReadQ)) begin
					dataRead <= readMux;
				end
			end else begin
				requestOutput <= 1'b0;
				dataRead <= busPkg::idleRead;
			end
		end
	end

	// tx done holds until the next byte is queued
	always_ff @(posedge clk) begin
		if (rst) begin
			txActiveQ <= 1'b0;
			txDone <= 1'b0;
		end else begin
			txActiveQ <= txActive;
			if (txBuf.push) begin
				txDone <= 1'b0;
			end else if (txActiveQ && !txActive) begin
				txDone <= 1'b1;
			end
		end
	end

	assign irq = (configReg[uartPkg::cfgLostIrqEnable]
			&& (flagStage[uartPkg::statRxLost] || flagStage[uartPkg::statTxLost]))
		|| (configReg[uartPkg::cfgRxIrqEnable] && flagStage[uartPkg::statRxAvailable])
		|| (configReg[uartPkg::cfgTxDoneIrqEnable] && txDone);

endmodule

// File: hdl/uartDevice.sv
`timescale 1ns/1ps

module uartDevice #(
	parameter busPkg::deviceId_t deviceId = '0,
	parameter int rxDepth = 32,
	parameter int txDepth = 32
) (
	input logic clk,
	input logic rst,

	input logic peripheralEnable,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input busPkg::busAddr_t peripheralBus_address,
	input busPkg::byteSel_t peripheralBus_byteSelect,
	input busPkg::busData_t peripheralBus_dataWrite,
	output busPkg::busData_t peripheralBus_dataRead,
	output logic peripheralBus_busy,
	output logic requestOutput,

	output logic uart_en,
	output logic uart_tx,
	output logic uart_irq,
	input logic uart_rx
);

	uartPkg::bitCycles_t cyclesPerBit;
	logic uartEnable;
	logic rxClear;
	logic txClear;
	logic txActive;
	logic rxValid;

	peripheralBusIf busIf();
	fifoIf rxBufIf();
	fifoIf txBufIf();

	assign busIf.enable = peripheralEnable;
	assign busIf.we = peripheralBus_we;
	assign busIf.oe = peripheralBus_oe;
	assign busIf.address = peripheralBus_address;
	assign busIf.byteSelect = peripheralBus_byteSelect;
	assign busIf.dataWrite = peripheralBus_dataWrite;

	assign uart_en = uartEnable;

	// serial side of the rx fifo
	assign rxBufIf.push = rxValid && uartEnable;

	uartRegisters #(.deviceId(deviceId)) uartRegisters_i (
		.clk(clk),
		.rst(rst),
		.bus(busIf.device),
		.dataRead(peripheralBus_dataRead),
		.requestOutput(requestOutput),
		.busy(peripheralBus_busy),
		.rxBuf(rxBufIf.user),
		.txBuf(txBufIf.user),
		.cyclesPerBit(cyclesPerBit),
		.uartEnable(uartEnable),
		.rxClear(rxClear),
		.txClear(txClear),
		.txActive(txActive),
		.irq(uart_irq)
	);

	byteFifo #(.depth(rxDepth)) rxFifo_i (
		.clk(clk),
		.rst(rst),
		.f(rxBufIf.buffer)
	);

	byteFifo #(.depth(txDepth)) txFifo_i (
		.clk(clk),
		.rst(rst),
		.f(txBufIf.buffer)
	);

	// line idles high while disabled
	uartRx uartRx_i (
		.clk(clk),
		.rst(rst),
		.clear(rxClear),
		.cyclesPerBit(cyclesPerBit),
		.rx(uartEnable ? uart_rx : 1'b1),
		.dataOut(rxBufIf.dataIn),
		.dataValid(rxValid)
	);

	uartTx uartTx_i (
		.clk(clk),
		.rst(rst),
		.clear(txClear),
		.cyclesPerBit(cyclesPerBit),
		.enable(uartEnable),
		.dataIn(txBufIf.dataOut),
		.dataReady(txBufIf.isData),
		.pop(txBufIf.pop),
		.tx(uart_tx),
		.active(txActive)
	);

endmodule

// File: tests/uartDeviceTb.sv
`timescale 1ns/1ps

module uartDeviceTb;

	localparam busPkg::deviceId_t devId = 4'h5;
	localparam busPkg::deviceId_t otherId = 4'h6;
	localparam int bitCycles = 7;
	localparam int waitLimit = 2000;
	localparam logic [11:0] offConfig = 12'h000;
	localparam logic [11:0] offClear = 12'h004;
	localparam logic [11:0] offStatus = 12'h008;
	localparam logic [11:0] offRx = 12'h00C;
	localparam logic [11:0] offTx = 12'h010;
	// configuration words with cycles per bit in the low half
	localparam logic [31:0] cfgBits = 32'h0000_0007;
	localparam logic [31:0] cfgWait = 32'h0001_0000;
	localparam logic [31:0] cfgEnable = 32'h0002_0000;
	localparam logic [31:0] cfgLostIrq = 32'h0004_0000;
	localparam logic [31:0] cfgRxIrq = 32'h0008_0000;
	localparam logic [31:0] cfgTxDoneIrq = 32'h0010_0000;

	logic clk;
	logic rst;
	logic peripheralEnable;
	logic peripheralBus_we;
	logic peripheralBus_oe;
	logic [15:0] peripheralBus_address;
	logic [3:0] peripheralBus_byteSelect;
	logic [31:0] peripheralBus_dataWrite;
	logic [31:0] peripheralBus_dataRead;
	logic peripheralBus_busy;
	logic requestOutput;
	logic uart_en;
	logic uart_tx;
	logic uart_irq;
	logic uart_rx;

	logic [31:0] lfsr;
	logic sawBusy;
	logic [7:0] txExpected[$];
	logic [7:0] rxExpected[$];

	uartDevice #(.deviceId(devId)) uartDevice_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsrStep(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	task automatic failNow();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic reportTimeout(input string what);
		$display("timed out waiting for %s", what);
		failNow();
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
			failNow();
		end
	endtask

	task automatic busWrite(input logic [11:0] offset, input logic [31:0] data,
			input logic [3:0] lanes);
		int i;
		logic stalled;
		logic done;
		done = 1'b0;
		@(posedge clk);
		#1;
		peripheralEnable = 1'b1;
		peripheralBus_we = 1'b1;
		peripheralBus_address = {devId, offset};
		peripheralBus_byteSelect = lanes;
		peripheralBus_dataWrite = data;
		// taken at the first edge with busy low
		for (i = 0; i < waitLimit && !done; i++) begin
			@(negedge clk);
			stalled = peripheralBus_busy;
			sawBusy = sawBusy | stalled;
			@(posedge clk);
			done = !stalled;
		end
		#1;
		peripheralEnable = 1'b0;
		peripheralBus_we = 1'b0;
		if (!done) begin
			reportTimeout("busy to fall during a write");
		end
	endtask

	task automatic busRead(input logic [11:0] offset, output logic [31:0] data);
		int i;
		logic got;
		got = 1'b0;
		@(posedge clk);
		#1;
		peripheralEnable = 1'b1;
		peripheralBus_oe = 1'b1;
		peripheralBus_address = {devId, offset};
		for (i = 0; i < waitLimit && !got; i++) begin
			@(posedge clk);
			#1;
			got = requestOutput;
		end
		data = peripheralBus_dataRead;
		peripheralEnable = 1'b0;
		peripheralBus_oe = 1'b0;
		if (!got) begin
			reportTimeout("requestOutput on a read");
		end
	endtask

	task automatic checkStatus(input logic [31:0] expected);
		logic [31:0] value;
		// flags pass two register stages
		repeat (4) @(posedge clk);
		busRead(offStatus, value);
		checkValue("status", expected, value);
	endtask

	task automatic waitIrq(input logic level);
		int i;
		logic found;
		found = 1'b0;
		for (i = 0; i < waitLimit && !found; i++) begin
			@(negedge clk);
			found = (uart_irq == level);
		end
		if (!found) begin
			reportTimeout("uart_irq to change level");
		end
	endtask

	task automatic sendByte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			uart_rx = frame[i];
			repeat (bitCycles) @(posedge clk);
		end
	endtask

	task automatic receiveByte(output logic [7:0] b);
		int i;
		logic seen;
		seen = 1'b0;
		b = '0;
		for (i = 0; i < waitLimit && !seen; i++) begin
			@(negedge clk);
			seen = !uart_tx;
		end
		if (!seen) begin
			reportTimeout("a start bit on uart_tx");
		end
		// sample mid start bit and every bit period after
		repeat ((bitCycles + 1) / 2) @(negedge clk);
		checkValue("uart_tx start bit", 32'd0, {31'd0, uart_tx});
		for (i = 0; i < 8; i++) begin
			repeat (bitCycles + 1) @(negedge clk);
			b[i] = uart_tx;
		end
		repeat (bitCycles + 1) @(negedge clk);
		checkValue("uart_tx stop bit", 32'd1, {31'd0, uart_tx});
	endtask

	task automatic writeTxBytes(input int count);
		logic [7:0] b;
		int i;
		for (i = 0; i < count; i++) begin
			b = randomByte();
			txExpected.push_back(b);
			busWrite(offTx, {24'd0, b}, 4'b0001);
		end
	endtask

	task automatic checkTxFrames(input int count);
		logic [7:0] b;
		int i;
		for (i = 0; i < count; i++) begin
			receiveByte(b);
			if (txExpected.size() == 0) begin
				$display("uart_tx sent a byte that was never written");
				failNow();
			end
			checkValue("uart_tx byte", {24'd0, txExpected.pop_front()}, {24'd0, b});
		end
	endtask

	task automatic sendRxBytes(input int count, input int keep);
		logic [7:0] b;
		int i;
		for (i = 0; i < count; i++) begin
			b = randomByte();
			if (i < keep) begin
				rxExpected.push_back(b);
			end
			sendByte(b);
		end
	endtask

	task automatic checkRxReads(input int count);
		logic [31:0] value;
		int i;
		for (i = 0; i < count; i++) begin
			busRead(offRx, value);
			checkValue("rx data", {23'd0, 1'b1, rxExpected.pop_front()}, value);
		end
	endtask

	initial begin
		logic [31:0] value;
		lfsr = 32'h17be_bb04;
		sawBusy = 1'b0;
		rst = 1'b1;
		peripheralEnable = 1'b0;
		peripheralBus_we = 1'b0;
		peripheralBus_oe = 1'b0;
		peripheralBus_address = '0;
		peripheralBus_byteSelect = '0;
		peripheralBus_dataWrite = '0;
		uart_rx = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// reset state and device select
		busRead(offConfig, value);
		checkValue("config", 32'h0000_1047, value);
		checkStatus(32'h0);
		checkValue("uart_tx", 32'd1, {31'd0, uart_tx});
		checkValue("uart_irq", 32'd0, {31'd0, uart_irq});
		checkValue("uart_en", 32'd0, {31'd0, uart_en});
		@(posedge clk);
		#1;
		peripheralEnable = 1'b1;
		peripheralBus_oe = 1'b1;
		peripheralBus_address = {otherId, offConfig};
		repeat (2) begin
			@(posedge clk);
			#1;
			checkValue("requestOutput", 32'd0, {31'd0, requestOutput});
			checkValue("dataRead", 32'hffff_ffff, peripheralBus_dataRead);
		end
		peripheralEnable = 1'b0;
		peripheralBus_oe = 1'b0;

		// transmit
		busWrite(offConfig, cfgEnable | cfgTxDoneIrq | cfgBits, 4'b0111);
		checkValue("uart_en", 32'd1, {31'd0, uart_en});
		fork
			writeTxBytes(20);
			checkTxFrames(20);
		join
		// last stop bit still on the line
		checkValue("uart_irq", 32'd0, {31'd0, uart_irq});
		waitIrq(1'b1);

		// receive
		busWrite(offConfig, cfgEnable | cfgRxIrq | cfgBits, 4'b0111);
		waitIrq(1'b0);
		sendRxBytes(20, 20);
		waitIrq(1'b1);
		checkRxReads(20);
		busRead(offRx, value);
		checkValue("rx data available", 32'd0, value & 32'h100);
		waitIrq(1'b0);

		// rx overflow and clear of the rx FIFO
		busWrite(offConfig, cfgEnable | cfgLostIrq | cfgBits, 4'b0111);
		sendRxBytes(34, 32);
		checkStatus(32'h07);
		waitIrq(1'b1);
		checkRxReads(32);
		sendRxBytes(2, 0);
		checkStatus(32'h05);
		busWrite(offClear, 32'h4, 4'b0001);
		checkStatus(32'h0);
		waitIrq(1'b0);

		// master held off by busy
		busWrite(offConfig, cfgEnable | cfgWait | cfgBits, 4'b0111);
		sawBusy = 1'b0;
		fork
			writeTxBytes(40);
			checkTxFrames(40);
		join
		checkValue("busy seen", 32'd1, {31'd0, sawBusy});
		checkStatus(32'h0);

		// tx FIFO only fills while disabled
		busWrite(offConfig, cfgBits, 4'b0111);
		writeTxBytes(33);
		txExpected.delete();
		checkStatus(32'h38);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: vlog.f
common/busPkg.sv
common/uartPkg.sv
common/peripheralBusIf.sv
common/fifoIf.sv
hdl/byteFifo.sv
uart/uartRx.sv
uart/uartTx.sv
hdl/uartRegisters.sv
hdl/uartDevice.sv
tests/uartDeviceTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= uartDeviceTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
